// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := image_filter_tb
FILELIST   := image_filter.f
BUILD_DIR  := obj_dir
PASS_MSG   := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run passes only if the testbench printed the pass line.
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: image_filter.f
+incdir+rtl
rtl/pixel_pkg.sv
rtl/kernel_pkg.sv
rtl/vertical_sliding_window.sv
rtl/horizontal_sliding_window.sv
rtl/gaussian_smoother.sv
rtl/image_filter_top.sv
verification/image_filter_tb.sv

// File: rtl/gaussian_smoother.sv
`timescale 1ns/1ps

`include "image_filter_defines.svh"

module gaussian_smoother (
    input bit clock_i,
    input bit reset_i,

    input bit window_valid_i,
    output bit window_ready_o,
    input pixel_pkg::pixel_column_t window_left_i,
    input pixel_pkg::pixel_column_t window_centre_i,
    input pixel_pkg::pixel_column_t window_right_i,

    output bit filtered_valid_o,
    input bit filtered_ready_i,
    output pixel_pkg::pixel_t filtered_pixel_o
);

    import pixel_pkg::*;
    import kernel_pkg::*;

    localparam int Size = `FILTER_WINDOW_SIZE;
    localparam int NormShift = 4;  // Divide by 16.

    // Indexed [column][row]; the kernel is symmetric.
    localparam weight_t Weights [Size][Size] = '{
        '{3'd1, 3'd2, 3'd1},
        '{3'd2, 3'd4, 3'd2},
        '{3'd1, 3'd2, 3'd1}
    };

    // Sixteen times the brightest pixel.
    localparam kernel_sum_t MaxSum = kernel_sum_t'((2 ** $bits(pixel_t) - 1) << NormShift);

    pixel_column_t window [Size];

    assign window[0] = window_left_i;
    assign window[1] = window_centre_i;
    assign window[2] = window_right_i;

    assign window_ready_o = reset_i && filtered_ready_i;

    // ############################################################
    // Weighted sum.
    // ############################################################

    kernel_sum_t weighted_sum;

    always_comb begin
        weighted_sum = '0;
        for (int c = 0; c < Size; c++) begin
            for (int r = 0; r < Size; r++) begin
                weighted_sum = weighted_sum
                    + kernel_sum_t'(Weights[c][r]) * kernel_sum_t'(window[c][r]);
            end
        end
    end

    // ############################################################
    // Output register.
    // ############################################################

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            filtered_valid_o <= 1'b0;
        end else if (filtered_ready_i) begin
            filtered_valid_o <= window_valid_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (filtered_ready_i) begin
            filtered_pixel_o <= pixel_t'(weighted_sum >> NormShift);  // Truncates.
        end
    end

    // Upstream windows hold real pixels, so no overflow into the top bits.
    assert property (@(posedge clock_i) disable iff (!reset_i)
        window_valid_i |-> weighted_sum <= MaxSum);

endmodule : gaussian_smoother

// File: rtl/horizontal_sliding_window.sv
`timescale 1ns/1ps

`include "image_filter_defines.svh"

module horizontal_sliding_window #(
    parameter int InWidth = `IMAGE_WIDTH
) (
    input bit clock_i,
    input bit reset_i,

    input bit column_valid_i,
    output bit column_ready_o,
    input pixel_pkg::pixel_column_t column_data_i,

    output bit window_valid_o,
    input bit window_ready_i,
    output pixel_pkg::pixel_column_t window_left_o,
    output pixel_pkg::pixel_column_t window_centre_o,
    output pixel_pkg::pixel_column_t window_right_o
);

    typedef bit [$clog2(InWidth + 1)-1:0] count_t;  // Can represent InWidth itself.

    localparam count_t LastColumn = count_t'(InWidth - 1);
    localparam count_t FirstFull = count_t'(`FILTER_WINDOW_SIZE - 1);

    bit accept;
    count_t column_count;

    assign column_ready_o = reset_i && window_ready_i;
    assign accept = column_valid_i && column_ready_o;

    // Position of the accepted column within its line.
    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            column_count <= '0;
        end else if (accept) begin
            if (column_count == LastColumn) begin
                column_count <= '0;
            end else begin
                column_count <= column_count + 1'b1;
            end
        end
    end

    // ############################################################
    // Column shift register.
    // ############################################################

    always_ff @(posedge clock_i) begin
        if (accept) begin
            window_left_o <= window_centre_o;
            window_centre_o <= window_right_o;
            window_right_o <= column_data_i;
        end
    end

    // Only windows whose three columns share a line.
    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            window_valid_o <= 1'b0;
        end else if (window_ready_i) begin
            window_valid_o <= accept && column_count >= FirstFull;
        end
    end

    assert property (@(posedge clock_i) disable iff (!reset_i)
        column_count <= LastColumn);

endmodule : horizontal_sliding_window

// File: rtl/image_filter_defines.svh
`ifndef IMAGE_FILTER_DEFINES_SVH
`define IMAGE_FILTER_DEFINES_SVH

// ############################################################
// Filter geometry.
// ############################################################

// Window height and width.
`define FILTER_WINDOW_SIZE 3

`define PIXEL_BITS 8  // Grayscale sample width.

// ############################################################
// Image size, kept small for simulation.
// ############################################################

`define IMAGE_WIDTH 8   // Pixels per line.
`define IMAGE_HEIGHT 6  // Lines per frame.

`endif

// File: rtl/image_filter_top.sv
`timescale 1ns/1ps

`include "image_filter_defines.svh"

module image_filter_top (
    input bit clock_i,
    input bit reset_i,

    input bit pixel_valid_i,
    output bit pixel_ready_o,
    input pixel_pkg::pixel_t pixel_i,

    output bit filtered_valid_o,
    input bit filtered_ready_i,
    output pixel_pkg::pixel_t filtered_pixel_o
);

    import pixel_pkg::*;

    // Line buffer to column shift.
    bit column_valid;
    bit column_ready;
    pixel_column_t column_data;

    // Column shift to smoother.
    bit window_valid;
    bit window_ready;
    pixel_column_t window_left;
    pixel_column_t window_centre;
    pixel_column_t window_right;

    vertical_sliding_window #(
        .InWidth(`IMAGE_WIDTH),
        .InHeight(`IMAGE_HEIGHT)
    ) vertical_i (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .pixel_valid_i(pixel_valid_i),
        .pixel_ready_o(pixel_ready_o),
        .pixel_i(pixel_i),
        .column_valid_o(column_valid),
        .column_ready_i(column_ready),
        .column_data_o(column_data)
    );

    horizontal_sliding_window #(
        .InWidth(`IMAGE_WIDTH)
    ) horizontal_i (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .column_valid_i(column_valid),
        .column_ready_o(column_ready),
        .column_data_i(column_data),
        .window_valid_o(window_valid),
        .window_ready_i(window_ready),
        .window_left_o(window_left),
        .window_centre_o(window_centre),
        .window_right_o(window_right)
    );

    gaussian_smoother smoother_i (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .window_valid_i(window_valid),
        .window_ready_o(window_ready),
        .window_left_i(window_left),
        .window_centre_i(window_centre),
        .window_right_i(window_right),
        .filtered_valid_o(filtered_valid_o),
        .filtered_ready_i(filtered_ready_i),
        .filtered_pixel_o(filtered_pixel_o)
    );

endmodule : image_filter_top

// File: rtl/kernel_pkg.sv
`include "image_filter_defines.svh"

package kernel_pkg;

    // Coefficient of the 1-2-1 by 1-2-1 kernel, largest is 4.
    typedef bit [2:0] weight_t;

    // Nine weighted pixels; the weights add up to 16, hence 4 extra bits.
    typedef bit [`PIXEL_BITS+3:0] kernel_sum_t;

endpackage : kernel_pkg

// File: rtl/pixel_pkg.sv
`include "image_filter_defines.svh"

package pixel_pkg;

    // One grayscale sample.
    typedef bit [`PIXEL_BITS-1:0] pixel_t;

    // Vertical column of the window, oldest line at index 0.
    typedef pixel_t [`FILTER_WINDOW_SIZE-1:0] pixel_column_t;

    // Position within the image.
    typedef bit [$clog2(`IMAGE_WIDTH)-1:0] column_t;
    typedef bit [$clog2(`IMAGE_HEIGHT)-1:0] row_t;

endpackage : pixel_pkg

// File: rtl/vertical_sliding_window.sv
`timescale 1ns/1ps

`include "image_filter_defines.svh"

module vertical_sliding_window #(
    parameter int InWidth = `IMAGE_WIDTH,
    parameter int InHeight = `IMAGE_HEIGHT
) (
    input bit clock_i,
    input bit reset_i,

    input bit pixel_valid_i,
    output bit pixel_ready_o,
    input pixel_pkg::pixel_t pixel_i,

    output bit column_valid_o,
    input bit column_ready_i,
    output pixel_pkg::pixel_column_t column_data_o
);

    import pixel_pkg::*;

    localparam int LineCount = `FILTER_WINDOW_SIZE - 1;  // Stored lines.

    typedef bit [$clog2(InWidth)-1:0] line_column_t;
    typedef bit [$clog2(InHeight)-1:0] line_row_t;
    typedef bit [$clog2(LineCount)-1:0] line_select_t;

    bit accept;

    assign pixel_ready_o = reset_i && column_ready_i;
    assign accept = pixel_valid_i && pixel_ready_o;

    // ############################################################
    // Raster position of the incoming pixel.
    // ############################################################

    line_row_t row, next_row;
    line_column_t column, next_column;

    always_comb begin
        if (column == line_column_t'(InWidth - 1)) begin
            next_column = '0;
            if (row == line_row_t'(InHeight - 1)) begin
                next_row = '0;  // Next frame.
            end else begin
                next_row = row + 1'b1;
            end
        end else begin
            next_column = column + 1'b1;
            next_row = row;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            row <= '0;
            column <= '0;
        end else if (accept) begin
            row <= next_row;
            column <= next_column;
        end
    end

    // ############################################################
    // Line memories.
    // ############################################################

    // Memory row % LineCount is overwritten by the current line.
    line_select_t write_line;
    assign write_line = line_select_t'(row % line_row_t'(LineCount));

    pixel_t line_reads [LineCount];

    for (genvar i = 0; i < LineCount; i++) begin : gen_line
        pixel_t line_mem [InWidth];
        pixel_t prefetch;

        always_ff @(posedge clock_i) begin
            if (accept) begin
                prefetch <= line_mem[next_column];  // Ready for the next pixel.
                if (write_line == line_select_t'(i)) begin
                    line_mem[column] <= pixel_i;
                end
            end
            if (column_ready_i) begin
                line_reads[i] <= prefetch;
            end
        end
    end : gen_line

    line_select_t read_line;
    pixel_t live_pixel;

    always_ff @(posedge clock_i) begin
        if (column_ready_i) begin
            read_line <= write_line;
            live_pixel <= pixel_i;
        end
    end

    // Rotate so that the oldest line lands at index 0.
    always_comb begin
        for (int i = 0; i < LineCount; i++) begin
            column_data_o[i] = line_reads[(int'(read_line) + i) % LineCount];
        end
        column_data_o[LineCount] = live_pixel;  // Newest line.
    end

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            column_valid_o <= 1'b0;
        end else if (column_ready_i) begin
            column_valid_o <= accept && row >= line_row_t'(LineCount);
        end
    end

    // Output must hold while the next stage stalls.
    assert property (@(posedge clock_i) disable iff (!reset_i)
        !column_ready_i |=> $stable(column_valid_o) && $stable(column_data_o));

endmodule : vertical_sliding_window

// File: verification/image_filter_tb.sv
`timescale 1ns/1ps

`include "image_filter_defines.svh"

module image_filter_tb;

    import pixel_pkg::*;

    localparam int ClockPeriod = 4;
    localparam int ResetCycles = 4;
    localparam int DrainCycles = 50;
    localparam int FramePixels = `IMAGE_WIDTH * `IMAGE_HEIGHT;
    localparam int FrameOutputs = (`IMAGE_WIDTH - 2) * (`IMAGE_HEIGHT - 2);
    localparam string DataFile = "verification/image_filter_testdata.txt";

    bit clock_i;
    bit reset_i;
    bit pixel_valid_i;
    bit pixel_ready_o;
    pixel_t pixel_i;
    bit filtered_valid_o;
    bit filtered_ready_i;
    pixel_t filtered_pixel_o;

    // Test table from the data file.
    string test_names [$];
    bit test_gaps [$];
    bit test_stalls [$];
    pixel_t in_pixels [$];
    pixel_t exp_pixels [$];

    bit loaded;
    bit load_ok;
    bit stray_output;
    int monitor_test;  // Test whose outputs are being checked.
    int passed_tests;
    int failed_tests;
    int ready_errors;
    int watchdog_ns;

    image_filter_top dut_i (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .pixel_valid_i(pixel_valid_i),
        .pixel_ready_o(pixel_ready_o),
        .pixel_i(pixel_i),
        .filtered_valid_o(filtered_valid_o),
        .filtered_ready_i(filtered_ready_i),
        .filtered_pixel_o(filtered_pixel_o)
    );

    initial begin
        clock_i = 1'b0;
        forever #(ClockPeriod / 2) clock_i = ~clock_i;
    end

    // ############################################################
    // Data file and stimulus.
    // ############################################################

    task automatic load_test_data(output bit ok);
        int fd;
        int code;
        int gaps;
        int stalls;
        int value;
        string word;
        string rest;
        ok = 1'b0;
        fd = $fopen(DataFile, "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", word);
            if (code != 1) begin
                break;
            end
            if (word.substr(0, 1) == "//") begin
                code = $fgets(rest, fd);  // Skip the comment.
                continue;
            end
            code = $fscanf(fd, "%d %d", gaps, stalls);
            if (code != 2) begin
                $fclose(fd);
                return;
            end
            test_names.push_back(word);
            test_gaps.push_back(gaps != 0);
            test_stalls.push_back(stalls != 0);
            for (int i = 0; i < FramePixels + FrameOutputs; i++) begin
                code = $fscanf(fd, "%h", value);
                if (code != 1) begin
                    $fclose(fd);
                    return;
                end
                if (i < FramePixels) begin
                    in_pixels.push_back(pixel_t'(value));
                end else begin
                    exp_pixels.push_back(pixel_t'(value));
                end
            end
        end
        $fclose(fd);
        ok = test_names.size() > 0;
    endtask

    // Holds the pixel until the DUT takes it.
    task automatic wait_for_pixel_accept();
        bit accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clock_i);
            accepted = pixel_ready_o;
            @(posedge clock_i);
            #1;
        end
    endtask

    // Frames follow each other with no idle cycles unless gaps are on.
    task automatic drive_frames();
        int index;
        index = 0;
        for (int t = 0; t < test_names.size(); t++) begin
            for (int p = 0; p < FramePixels; p++) begin
                while (test_gaps[t] && $urandom % 4 == 0) begin
                    pixel_valid_i = 1'b0;
                    @(posedge clock_i);
                    #1;
                end
                pixel_valid_i = 1'b1;
                pixel_i = in_pixels[index];
                wait_for_pixel_accept();
                index++;
            end
        end
        pixel_valid_i = 1'b0;
    endtask

    // ############################################################
    // Output checking.
    // ############################################################

    task automatic check_outputs();
        int index;
        int errors;
        int count;
        index = 0;
        for (int t = 0; t < test_names.size(); t++) begin
            monitor_test = t;
            errors = 0;
            count = 0;
            while (count < FrameOutputs) begin
                @(negedge clock_i);  // Transfer happens at the next rising edge.
                if (filtered_valid_o && filtered_ready_i) begin
                    if (filtered_pixel_o != exp_pixels[index]) begin
                        $display(
                            "Error: filtered_pixel_o expected 0x%02h, got 0x%02h (%s, pixel %0d)",
                            exp_pixels[index], filtered_pixel_o, test_names[t], count);
                        errors++;
                    end
                    index++;
                    count++;
                end
            end
            if (errors == 0) begin
                passed_tests++;
            end else begin
                failed_tests++;
            end
            $display("Test %s: %0d outputs, %0d mismatches", test_names[t], count, errors);
        end
        monitor_test = test_names.size();
    endtask

    // Input ready follows the output ready and is low in reset.
    always @(negedge clock_i) begin
        if (pixel_ready_o != (reset_i && filtered_ready_i)) begin
            $display("Error: pixel_ready_o expected 0x%0h, got 0x%0h",
                reset_i && filtered_ready_i, pixel_ready_o);
            ready_errors++;
        end
    end

    // Random output stalls for the tests that ask for them.
    initial begin
        forever begin
            @(posedge clock_i);
            #1;
            if (loaded && monitor_test < test_stalls.size() && test_stalls[monitor_test]) begin
                filtered_ready_i = ($urandom % 3) != 0;
            end else begin
                filtered_ready_i = 1'b1;
            end
        end
    end

    initial begin
        wait (loaded);
        #(watchdog_ns);
        $display("Timeout: the filter stopped delivering output pixels.");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(89));
        reset_i = 1'b0;
        pixel_valid_i = 1'b0;
        pixel_i = '0;
        filtered_ready_i = 1'b1;
        load_test_data(load_ok);
        if (load_ok) begin
            watchdog_ns = 4 * in_pixels.size() * ClockPeriod
                + (ResetCycles + DrainCycles + 100) * ClockPeriod;
            loaded = 1'b1;
            repeat (ResetCycles) @(posedge clock_i);
            #1 reset_i = 1'b1;
            fork
                drive_frames();
                check_outputs();
            join
            // Nothing may follow the last frame.
            @(posedge clock_i);
            repeat (DrainCycles) begin
                @(negedge clock_i);
                if (filtered_valid_o) begin
                    stray_output = 1'b1;
                end
            end
            if (stray_output) begin
                $display("An output pixel appeared after the last frame was complete.");
            end
        end else begin
            $display("Could not read the test data file %s.", DataFile);
        end
        $display("Tests passed: %0d, failed: %0d", passed_tests, failed_tests);
        if (load_ok && failed_tests == 0 && ready_errors == 0 && !stray_output) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : image_filter_tb

// File: verification/image_filter_testdata.txt
// Per test: name, input gaps (0/1), output stalls (0/1), then
// 6 input rows of 8 hex pixels and 4 expected rows of 6 hex pixels.
flat 0 0
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
40 40 40 40 40 40 40 40
40 40 40 40 40 40
40 40 40 40 40 40
40 40 40 40 40 40
40 40 40 40 40 40

hramp 0 0
00 13 27 3C 52 69 81 9A
00 13 27 3C 52 69 81 9A
00 13 27 3C 52 69 81 9A
00 13 27 3C 52 69 81 9A
00 13 27 3C 52 69 81 9A
00 13 27 3C 52 69 81 9A
13 27 3C 52 69 81
13 27 3C 52 69 81
13 27 3C 52 69 81
13 27 3C 52 69 81

vramp 1 0
05 05 05 05 05 05 05 05
0A 0A 0A 0A 0A 0A 0A 0A
20 20 20 20 20 20 20 20
41 41 41 41 41 41 41 41
80 80 80 80 80 80 80 80
FF FF FF FF FF FF FF FF
0E 0E 0E 0E 0E 0E
22 22 22 22 22 22
48 48 48 48 48 48
90 90 90 90 90 90

impulse 1 1
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 FF 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 0F 1F 0F 00 00
00 1F 3F 1F 00 00
00 0F 1F 0F 00 00
00 00 00 00 00 00
